// ==== hw/alu.sv ====
`include "cpu_macros.svh"

module alu (
	input logic [`DATA_WIDTH-1:0] srcA,
	input logic [`DATA_WIDTH-1:0] srcB,
	input logic [2:0] aluControl,
	output logic [`DATA_WIDTH-1:0] result,
	output logic zero
);

	// Shared subtractor for SUB and SLT
	logic [`DATA_WIDTH-1:0] diff;
	logic lessThan;

	assign diff = srcA - srcB;

	// Signed compare
	assign lessThan = $signed(srcA) < $signed(srcB);

	always_comb begin
		case (aluControl)
			`ALU_AND: result = srcA & srcB;
			`ALU_OR: result = srcA | srcB;
			`ALU_ADD: result = srcA + srcB;
			`ALU_SUB: result = diff;
			// Zero-extended one-bit flag
			`ALU_SLT: result = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
			default: result = srcA + srcB;
		endcase
	end

	// BEQ looks at this after SUB
	assign zero = (result == '0);

endmodule

// ==== hw/aluDecoder.sv ====
`include "cpu_macros.svh"

module aluDecoder import cpuPkg::*; (
	input aluOp_t aluOp,
	input logic [5:0] funct,
	output logic [2:0] aluControl
);

	always_comb begin
		case (aluOp)
			// Address, PC increment and branch target
			aluOpAdd: aluControl = `ALU_ADD;
			// BEQ compare
			aluOpSub: aluControl = `ALU_SUB;
			// R-type, look at the function field
			aluOpFunct: begin
				case (funct)
					`FN_ADD: aluControl = `ALU_ADD;
					`FN_SUB: aluControl = `ALU_SUB;
					`FN_AND: aluControl = `ALU_AND;
					`FN_OR: aluControl = `ALU_OR;
					`FN_SLT: aluControl = `ALU_SLT;
					// Unknown function falls back to add
					default: aluControl = `ALU_ADD;
				endcase
			end
			default: aluControl = `ALU_ADD;
		endcase
	end

endmodule

// ==== hw/controlUnit.sv ====
`include "cpu_macros.svh"

module controlUnit import cpuPkg::*; (
	input logic clk,
	input logic rstb,
	input logic [5:0] opcode,
	input logic [5:0] funct,
	input logic zero,
	input logic memReady,
	output logic memValid,
	output logic memWrite,
	output logic pcWrite,
	output logic branch,
	output logic iOrD,
	output logic irWrite,
	output logic mdrWrite,
	output logic regWrite,
	output logic memToReg,
	output logic regDst,
	output logic aluSrcA,
	output logic [1:0] aluSrcB,
	output logic [1:0] pcSrc,
	output aluOp_t aluOp
);

	ctrlState_t state;
	ctrlState_t nextState;
	logic xfer;
	logic functOk;

	// Handshake completes this cycle
	assign xfer = memValid & memReady;

	// Only the five supported R-type functions execute
	assign functOk = funct inside {`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT};

	always_comb begin
		nextState = state;
		case (state)
			// Memory states wait for the transfer
			stFetch: if (xfer) nextState = stDecode;
			stDecode: begin
				case (opcode)
					`OP_LW, `OP_SW: nextState = stMemAdr;
					`OP_RTYPE: nextState = functOk ? stExecute : stFetch;
					`OP_BEQ: nextState = stBranch;
					`OP_ADDI: nextState = stImmExec;
					`OP_J: nextState = stJump;
					// Unsupported opcode acts as a no-op
					default: nextState = stFetch;
				endcase
			end
			stMemAdr: nextState = (opcode == `OP_LW) ? stMemRead : stMemWrite;
			stMemRead: if (xfer) nextState = stMemWb;
			stMemWrite: if (xfer) nextState = stFetch;
			stExecute: nextState = stAluWb;
			stImmExec: nextState = stImmWb;
			default: nextState = stFetch;
		endcase
	end

	// State and memory request flops
	// Request levels follow the state being entered
	always_ff @(posedge clk) begin
		if (!rstb) begin
			state <= stFetch;
			memValid <= 1'b0;
			memWrite <= 1'b0;
		end else begin
			state <= nextState;
			memValid <= (nextState == stFetch) || (nextState == stMemRead) ||
				(nextState == stMemWrite);
			memWrite <= (nextState == stMemWrite);
		end
	end

	// Per-state control levels
	always_comb begin
		iOrD = 1'b0;
		branch = 1'b0;
		regWrite = 1'b0;
		memToReg = 1'b0;
		regDst = 1'b0;
		aluSrcA = 1'b0;
		aluSrcB = 2'b00;
		pcSrc = 2'b00;
		aluOp = aluOpAdd;
		case (state)
			// PC + 4
			stFetch: aluSrcB = 2'b01;
			// Branch target into aluOut
			stDecode: aluSrcB = 2'b11;
			// Base plus offset
			stMemAdr, stImmExec: begin
				aluSrcA = 1'b1;
				aluSrcB = 2'b10;
			end
			stMemRead, stMemWrite: iOrD = 1'b1;
			// Load result to rt
			stMemWb: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
			end
			stExecute: begin
				aluSrcA = 1'b1;
				aluOp = aluOpFunct;
			end
			stAluWb: begin
				regWrite = 1'b1;
				regDst = 1'b1;
			end
			// Compare rs and rt, target already in aluOut
			stBranch: begin
				aluSrcA = 1'b1;
				aluOp = aluOpSub;
				branch = 1'b1;
				pcSrc = 2'b01;
			end
			stImmWb: regWrite = 1'b1;
			stJump: pcSrc = 2'b10;
			default: ;
		endcase
	end

	// PC enable, fetch on transfer, jump always, BEQ only when equal
	assign pcWrite = ((state == stFetch) & xfer) | (state == stJump) | (branch & zero);

	// Capture enables tied to the transfer
	assign irWrite = (state == stFetch) & xfer;
	assign mdrWrite = (state == stMemRead) & xfer;

endmodule

// ==== hw/cpuPkg.sv ====
package cpuPkg;

	// Multicycle controller states
	typedef enum logic [3:0] {
		stFetch = 4'd0,
		stDecode = 4'd1,
		stMemAdr = 4'd2,
		stMemRead = 4'd3,
		stMemWb = 4'd4,
		stMemWrite = 4'd5,
		stExecute = 4'd6,
		stAluWb = 4'd7,
		stBranch = 4'd8,
		stImmExec = 4'd9,
		stImmWb = 4'd10,
		stJump = 4'd11
	} ctrlState_t;

	// ALU operation class from the controller
	typedef enum logic [1:0] {
		aluOpAdd = 2'b00,
		aluOpSub = 2'b01,
		aluOpFunct = 2'b10
	} aluOp_t;

	// Register form
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rForm_t;

	// Immediate form
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iForm_t;

	// One instruction word, two decodes
	// Jump target is bits 25..0 of either view
	typedef union packed {
		rForm_t r;
		iForm_t i;
	} instrWord_t;

endpackage

// ==== hw/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Word and address width
`define DATA_WIDTH 32

// Architectural register count
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Primary opcodes, instruction bits 31..26
`define OP_RTYPE 6'h00
`define OP_J 6'h02
`define OP_BEQ 6'h04
`define OP_ADDI 6'h08
`define OP_LW 6'h23
`define OP_SW 6'h2b

// R-type function field, bits 5..0
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_SLT 6'h2a

// ALU control codes
`define ALU_AND 3'b000
`define ALU_OR 3'b001
`define ALU_ADD 3'b010
`define ALU_SUB 3'b110
`define ALU_SLT 3'b111

`endif

// ==== hw/datapath.sv ====
`include "cpu_macros.svh"

module datapath import cpuPkg::*; (
	input logic clk,
	input logic rstb,
	input logic pcWrite,
	input logic branch,
	input logic iOrD,
	input logic irWrite,
	input logic mdrWrite,
	input logic memToReg,
	input logic regDst,
	input logic aluSrcA,
	input logic [1:0] aluSrcB,
	input logic [1:0] pcSrc,
	input aluOp_t aluOp,
	input logic [`DATA_WIDTH-1:0] memRdata,
	input logic [`DATA_WIDTH-1:0] regReadA,
	input logic [`DATA_WIDTH-1:0] regReadB,
	output logic [5:0] opcode,
	output logic [5:0] funct,
	output logic zero,
	output logic [`DATA_WIDTH-1:0] memAddr,
	output logic [`DATA_WIDTH-1:0] memWdata,
	output logic [4:0] regAddrA,
	output logic [4:0] regAddrB,
	output logic [4:0] regAddrW,
	output logic [`DATA_WIDTH-1:0] regWdata
);

	logic [`DATA_WIDTH-1:0] pc;
	instrWord_t ir;
	logic [`DATA_WIDTH-1:0] mdr;
	logic [`DATA_WIDTH-1:0] aReg;
	logic [`DATA_WIDTH-1:0] bReg;
	logic [`DATA_WIDTH-1:0] aluOut;
	logic [`DATA_WIDTH-1:0] immExt;
	logic [`DATA_WIDTH-1:0] srcA;
	logic [`DATA_WIDTH-1:0] srcB;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic [`DATA_WIDTH-1:0] pcNext;
	logic [2:0] aluControl;

	// Program counter
	always_ff @(posedge clk) begin
		if (!rstb) begin
			pc <= `RESET_PC;
		end else if (pcWrite) begin
			pc <= pcNext;
		end
	end

	// Instruction and load data, captured on transfer
	always_ff @(posedge clk) begin
		if (irWrite) begin
			ir <= memRdata;
		end
		if (mdrWrite) begin
			mdr <= memRdata;
		end
	end

	// Operand registers follow the register file
	// aluOut holds the data address and the branch target while in use
	always_ff @(posedge clk) begin
		aReg <= regReadA;
		bReg <= regReadB;
		if (!(iOrD || branch)) begin
			aluOut <= aluResult;
		end
	end

	// Field decode through both views
	assign opcode = ir.r.opcode;
	assign funct = ir.r.funct;
	assign regAddrA = ir.i.rs;
	assign regAddrB = ir.i.rt;
	assign immExt = {{16{ir.i.imm[15]}}, ir.i.imm};

	// ALU operands
	assign srcA = aluSrcA ? aReg : pc;
	always_comb begin
		case (aluSrcB)
			2'b00: srcB = bReg;
			2'b01: srcB = 32'd4;
			2'b10: srcB = immExt;
			default: srcB = {immExt[29:0], 2'b00};
		endcase
	end

	aluDecoder aluDec0 (
		.aluOp(aluOp),
		.funct(funct),
		.aluControl(aluControl)
	);

	alu alu0 (
		.srcA(srcA),
		.srcB(srcB),
		.aluControl(aluControl),
		.result(aluResult),
		.zero(zero)
	);

	// Next PC, jump uses the upper bits of PC + 4
	always_comb begin
		case (pcSrc)
			2'b01: pcNext = aluOut;
			2'b10: pcNext = {pc[31:28], ir[25:0], 2'b00};
			default: pcNext = aluResult;
		endcase
	end

	// Memory request, fetch from PC, data from aluOut
	assign memAddr = iOrD ? aluOut : pc;
	// Store data straight off the rt read port
	assign memWdata = regReadB;

	// Writeback destination and value
	assign regAddrW = regDst ? ir.r.rd : ir.i.rt;
	assign regWdata = memToReg ? mdr : aluOut;

endmodule

// ==== hw/mipsCore.sv ====
`include "cpu_macros.svh"

module mipsCore import cpuPkg::*; (
	input logic clk,
	input logic rstb,
	input logic memReady,
	input logic [`DATA_WIDTH-1:0] memRdata,
	output logic memValid,
	output logic memWrite,
	output logic [`DATA_WIDTH-1:0] memAddr,
	output logic [`DATA_WIDTH-1:0] memWdata
);

	// Controller to datapath
	logic pcWrite;
	logic branch;
	logic iOrD;
	logic irWrite;
	logic mdrWrite;
	logic regWrite;
	logic memToReg;
	logic regDst;
	logic aluSrcA;
	logic [1:0] aluSrcB;
	logic [1:0] pcSrc;
	aluOp_t aluOp;

	// Datapath to controller
	logic [5:0] opcode;
	logic [5:0] funct;
	logic zero;

	// Register file side
	logic [4:0] regAddrA;
	logic [4:0] regAddrB;
	logic [4:0] regAddrW;
	logic [`DATA_WIDTH-1:0] regWdata;
	logic [`DATA_WIDTH-1:0] regReadA;
	logic [`DATA_WIDTH-1:0] regReadB;

	controlUnit ctrl0 (
		.clk(clk),
		.rstb(rstb),
		.opcode(opcode),
		.funct(funct),
		.zero(zero),
		.memReady(memReady),
		.memValid(memValid),
		.memWrite(memWrite),
		.pcWrite(pcWrite),
		.branch(branch),
		.iOrD(iOrD),
		.irWrite(irWrite),
		.mdrWrite(mdrWrite),
		.regWrite(regWrite),
		.memToReg(memToReg),
		.regDst(regDst),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.pcSrc(pcSrc),
		.aluOp(aluOp)
	);

	datapath dp0 (
		.clk(clk),
		.rstb(rstb),
		.pcWrite(pcWrite),
		.branch(branch),
		.iOrD(iOrD),
		.irWrite(irWrite),
		.mdrWrite(mdrWrite),
		.memToReg(memToReg),
		.regDst(regDst),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.pcSrc(pcSrc),
		.aluOp(aluOp),
		.memRdata(memRdata),
		.regReadA(regReadA),
		.regReadB(regReadB),
		.opcode(opcode),
		.funct(funct),
		.zero(zero),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.regAddrA(regAddrA),
		.regAddrB(regAddrB),
		.regAddrW(regAddrW),
		.regWdata(regWdata)
	);

	regFile rf0 (
		.clk(clk),
		.rstb(rstb),
		.we(regWrite),
		.addrA(regAddrA),
		.addrB(regAddrB),
		.addrW(regAddrW),
		.wdata(regWdata),
		.rdataA(regReadA),
		.rdataB(regReadB)
	);

endmodule

// ==== hw/regFile.sv ====
`include "cpu_macros.svh"

module regFile (
	input logic clk,
	input logic rstb,
	input logic we,
	input logic [4:0] addrA,
	input logic [4:0] addrB,
	input logic [4:0] addrW,
	input logic [`DATA_WIDTH-1:0] wdata,
	output logic [`DATA_WIDTH-1:0] rdataA,
	output logic [`DATA_WIDTH-1:0] rdataB
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// All registers cleared, writes to $zero dropped
	always_ff @(posedge clk) begin
		if (!rstb) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (addrW != 5'd0)) begin
			regs[addrW] <= wdata;
		end
	end

	// Asynchronous reads, $zero forced
	assign rdataA = (addrA == 5'd0) ? '0 : regs[addrA];
	assign rdataB = (addrB == 5'd0) ? '0 : regs[addrB];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the cpuTb simulation with Verilator, run it, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module cpuTb \
	-f vlog.f \
	-Mdir obj_dir \
	-o cpuSim

status=0
output=$(./obj_dir/cpuSim 2>&1) || status=$?
echo "$output"

if grep -qx "Simulation finished: PASS" <<< "$output"; then
	echo "run.sh: test passed"
else
	echo "run.sh: test failed (simulator status $status)" >&2
	exit 1
fi

// ==== verification/cpuTb.sv ====
`include "cpu_macros.svh"

module cpuTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_INSTR = 200;
	localparam int MEM_WORDS = 2048;
	localparam int DATA_BASE = 'h1000;
	localparam int DATA_WORDS = 256;
	localparam logic [31:0] HALT_ADDR = `RESET_PC + 32'((NUM_INSTR - 1) * 4);
	// Five cycles per instruction, four times over for stalls, plus reset and slack
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 5 * 4 + 16 + 500;

	logic clk = 1'b0;
	logic rstb = 1'b0;
	logic memReady = 1'b0;
	logic [`DATA_WIDTH-1:0] memRdata = '0;
	logic memValid;
	logic memWrite;
	logic [`DATA_WIDTH-1:0] memAddr;
	logic [`DATA_WIDTH-1:0] memWdata;

	// Program and data image, and the live memory the core sees
	logic [31:0] image [MEM_WORDS];
	logic [31:0] mem [MEM_WORDS];
	// Expected transfers in order
	logic expWrite [$];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	// Back-pressure state of the memory model
	logic busy = 1'b0;
	int waitCnt = 0;

	mipsCore dut0 (
		.clk(clk),
		.rstb(rstb),
		.memReady(memReady),
		.memRdata(memRdata),
		.memValid(memValid),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWdata(memWdata)
	);

	always #10 clk = ~clk;

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// Core must stay inside the modeled memory, word aligned
	task automatic checkAddress(input logic [31:0] addr);
		if ((addr >= 32'(MEM_WORDS * 4)) || (addr[1:0] != 2'b00)) begin
			$display("Core requested address 0x%08h outside the memory or unaligned", addr);
			$display("Simulation finished: FAIL");
			$fatal(1, "bad memory address");
		end
	endtask

	task automatic pushExpected(input logic wr, input logic [31:0] addr,
		input logic [31:0] data);
		expWrite.push_back(wr);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic buildProgram();
		logic [5:0] fns [5];
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		int span;
		int off;
		fns = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT};
		// Background fill tied to the word index
		for (int w = 0; w < MEM_WORDS; w++) begin
			image[w] = {~w[15:0], w[15:0]};
		end
		for (int w = 0; w < DATA_WORDS; w++) begin
			image[DATA_BASE / 4 + w] = $urandom;
		end
		for (int i = 0; i < NUM_INSTR - 1; i++) begin
			rs = 5'($urandom);
			rt = 5'($urandom);
			rd = 5'($urandom);
			// Forward hop, never past the halt jump
			span = (NUM_INSTR - 1 - i < 8) ? NUM_INSTR - 1 - i : 8;
			off = int'($urandom % span);
			case ($urandom % 9)
				0, 1, 2: image[i] = encR(rs, rt, rd, fns[3'($urandom % 5)]);
				3: image[i] = encI(`OP_ADDI, rs, rt, 16'($urandom));
				4: image[i] = encI(`OP_LW, 5'd0, rt, 16'(DATA_BASE + 4 * ($urandom % DATA_WORDS)));
				5, 6: image[i] = encI(`OP_SW, 5'd0, rt,
					16'(DATA_BASE + 4 * ($urandom % DATA_WORDS)));
				// Same register half the time so some branches are taken
				7: image[i] = encI(`OP_BEQ, rs, ($urandom % 2) ? rs : rt, 16'(off));
				default: image[i] = {`OP_J, 26'((`RESET_PC + 4 * (i + 1 + off)) >> 2)};
			endcase
		end
		// Halt loop
		image[NUM_INSTR - 1] = {`OP_J, 26'(HALT_ADDR >> 2)};
	endtask

	// Instruction-set model, records every expected transfer
	task automatic runModel();
		logic [31:0] regs [32];
		logic [31:0] refMem [MEM_WORDS];
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [31:0] instr;
		logic [31:0] sext;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic done;
		refMem = image;
		regs = '{default: '0};
		pc = `RESET_PC;
		done = 1'b0;
		while (!done) begin
			instr = refMem[pc[12:2]];
			pushExpected(1'b0, pc, '0);
			sext = {{16{instr[15]}}, instr[15:0]};
			a = regs[instr[25:21]];
			b = regs[instr[20:16]];
			addr = a + sext;
			nextPc = pc + 32'd4;
			case (instr[31:26])
				`OP_RTYPE: begin
					case (instr[5:0])
						`FN_ADD: regs[instr[15:11]] = a + b;
						`FN_SUB: regs[instr[15:11]] = a - b;
						`FN_AND: regs[instr[15:11]] = a & b;
						`FN_OR: regs[instr[15:11]] = a | b;
						`FN_SLT: regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: ;
					endcase
				end
				`OP_ADDI: regs[instr[20:16]] = addr;
				`OP_LW: begin
					pushExpected(1'b0, addr, '0);
					regs[instr[20:16]] = refMem[addr[12:2]];
				end
				`OP_SW: begin
					pushExpected(1'b1, addr, b);
					refMem[addr[12:2]] = b;
				end
				`OP_BEQ: if (a == b) nextPc = nextPc + {sext[29:0], 2'b00};
				// Only J is left
				default: nextPc = {nextPc[31:28], instr[25:0], 2'b00};
			endcase
			// $zero is hardwired
			regs[0] = '0;
			done = (pc == HALT_ADDR);
			pc = nextPc;
		end
	endtask

	initial begin
		void'($urandom(44546));
		buildProgram();
		runModel();
		repeat (16) @(posedge clk);
		rstb <= 1'b1;
	end

	// Memory model with random wait states, checks every transfer
	always @(posedge clk) begin
		if (!rstb) begin
			memReady <= 1'b0;
			busy = 1'b0;
			mem = image;
		end else if (memValid && memReady) begin
			memReady <= 1'b0;
			busy = 1'b0;
			if (expAddr.size() == 0) begin
				// Halt jump fetched a second time
				compareValue("memWrite", 32'(memWrite), 32'd0);
				compareValue("memAddr", memAddr, HALT_ADDR);
				$display("Simulation finished: PASS");
				$finish;
			end else begin
				compareValue("memWrite", 32'(memWrite), 32'(expWrite.pop_front()));
				compareValue("memAddr", memAddr, expAddr.pop_front());
				if (memWrite) begin
					compareValue("memWdata", memWdata, expData[0]);
					mem[memAddr[12:2]] = memWdata;
				end
				void'(expData.pop_front());
			end
		end else if (memValid) begin
			// New request, pick 0 to 3 wait cycles
			if (!busy) begin
				busy = 1'b1;
				waitCnt = int'($urandom % 4);
			end
			if (waitCnt == 0) begin
				checkAddress(memAddr);
				memReady <= 1'b1;
				memRdata <= mem[memAddr[12:2]];
			end else begin
				waitCnt = waitCnt - 1;
			end
		end
	end

	// No request while reset is held
	always @(negedge clk) begin
		if (!rstb) begin
			compareValue("memValid", 32'(memValid), 32'd0);
			compareValue("memWrite", 32'(memWrite), 32'd0);
		end
	end

	// Watchdog
	initial begin
		#(TIMEOUT_CYCLES * 20);
		$display("Core did not reach the halt loop within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== verification/cpu_props.sv ====
`include "cpu_macros.svh"

module cpuProps (
	input logic clk,
	input logic rstb,
	input logic memValid,
	input logic memReady,
	input logic memWrite,
	input logic [`DATA_WIDTH-1:0] memAddr,
	input logic [`DATA_WIDTH-1:0] memWdata,
	input logic irWrite,
	input logic regWrite
);
	timeunit 1ns;
	timeprecision 1ps;

	// Request drops one cycle into reset
	resetQuiet: assert property (@(posedge clk) !rstb |=> !memValid && !memWrite)
		else $error("memory request active during reset");

	// Unaccepted request holds still
	holdRequest: assert property (@(posedge clk) disable iff (!rstb)
		memValid && !memReady |=> memValid && $stable(memWrite) && $stable(memAddr) &&
		$stable(memWdata))
		else $error("memory request changed before it was accepted");

	// Memory side answers only a live request
	readyInRequest: assert property (@(posedge clk) disable iff (!rstb) memReady |-> memValid)
		else $error("memReady high without memValid");

	// Store transfer goes straight to the next fetch
	writeThenFetch: assert property (@(posedge clk) disable iff (!rstb)
		memValid && memReady && memWrite |=> memValid && !memWrite)
		else $error("no fetch request right after a store");

	// Fetch leads into decode, which issues no request
	fetchThenDecode: assert property (@(posedge clk) disable iff (!rstb)
		irWrite |=> !memValid)
		else $error("memory request right after an instruction fetch");

	// Writeback states issue no request
	regWriteQuiet: assert property (@(posedge clk) disable iff (!rstb) regWrite |-> !memValid)
		else $error("register write overlaps a memory request");

endmodule

bind mipsCore cpuProps props0 (
	.clk(clk),
	.rstb(rstb),
	.memValid(memValid),
	.memReady(memReady),
	.memWrite(memWrite),
	.memAddr(memAddr),
	.memWdata(memWdata),
	.irWrite(irWrite),
	.regWrite(regWrite)
);

// ==== vlog.f ====
+incdir+hw
hw/cpuPkg.sv
hw/aluDecoder.sv
hw/alu.sv
hw/regFile.sv
hw/controlUnit.sv
hw/datapath.sv
hw/mipsCore.sv
verification/cpu_props.sv
verification/cpuTb.sv
